/* Bender.yml */
package:
  name: pocket_pokemon_mini

sources:
  - include_dirs:
      - hw
    files:
      - hw/pocket_pkg.sv
      - hw/bridge_regs.sv
      - hw/rom_loader.sv
      - hw/video_conditioner.sv
      - hw/pocket_core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_checker.sv
      - tests/tb_top.sv

/* files.f */
+incdir+hw
hw/pocket_pkg.sv
hw/bridge_regs.sv
hw/rom_loader.sv
hw/video_conditioner.sv
hw/pocket_core_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* hw/bridge_regs.sv */
// bridge register block
// settings register, write decode for the rom loader
// and the combinational read mux
`timescale 1ns/1ns
`include "pocket_consts.svh"

module bridge_regs (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  pocket_pkg::bridge_req_t    bridge,
  input  pocket_pkg::loader_status_t loader_status,
  output logic [31:0]                bridge_rd_data,
  output logic                       blending_enabled,
  output logic                       load_word_valid,
  output logic [31:0]                load_word,
  output logic [23:0]                load_offset,
  output logic                       load_done
);

  logic        hit_settings;
  logic        hit_loaddone;
  logic        hit_loader;
  logic        hit_status;
  logic [31:0] status_word;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // register hits use the full word
  assign hit_settings = bridge.addr.raw == `POCKET_REG_SETTINGS;
  assign hit_loaddone = bridge.addr.raw == `POCKET_REG_LOADDONE;
  // windows only look at the top bits
  assign hit_loader   = bridge.addr.rgn.region[7:4] == `POCKET_LOADER_REGION;
  assign hit_status   = bridge.addr.rgn.region == `POCKET_STATUS_REGION;

  // loader strobes, one cycle each since wr is a single-cycle pulse
  assign load_word_valid = bridge.wr & hit_loader;
  assign load_word       = bridge.wr_data;
  assign load_offset     = bridge.addr.rgn.offset;
  assign load_done       = bridge.wr & hit_loaddone & bridge.wr_data[0];

  //////////////////////////////
  // settings register
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      blending_enabled <= 1'b0;
    end else if (bridge.wr && hit_settings) begin
      blending_enabled <= bridge.wr_data[0];
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  // count on top, flags in the low bits
  assign status_word = {loader_status.byte_count, 6'b0,
                        loader_status.busy, loader_status.download};

  // same-cycle read data, no wait states on the bridge
  always_comb begin
    if (hit_status) begin
      bridge_rd_data = status_word;
    end else if (hit_settings) begin
      bridge_rd_data = {31'b0, blending_enabled};
    end else begin
      bridge_rd_data = 32'b0;
    end
  end

endmodule

/* hw/pocket_consts.svh */
// pokemon mini wrapper constants
// bridge address map, register offsets, widths and video timing
`ifndef POCKET_CONSTS_SVH
`define POCKET_CONSTS_SVH

//////////////////////////////
// bridge address map
//////////////////////////////

// upper nibble of the address, rom download window
`define POCKET_LOADER_REGION 4'h1
// upper byte of the address, status word
`define POCKET_STATUS_REGION 8'hF8

// settings register, bit 0 is blending enable
`define POCKET_REG_SETTINGS 32'h0000_0100
// write 1 in bit 0 to end the download
`define POCKET_REG_LOADDONE 32'h0000_0104

//////////////////////////////
// widths and timing
//////////////////////////////

`define POCKET_LOAD_ADDR_W 25
`define POCKET_HS_DELAY 3'd7
`define POCKET_RGB_W 24

`endif

/* hw/pocket_core_top.sv */
// pokemon mini user core wrapper
// bridge registers, rom loader, controller mapping
// and video conditioning, all on clk_74a
`timescale 1ns/1ns

module pocket_core_top (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  pocket_pkg::bridge_req_t   bridge,
  input  logic [15:0]               cont1_key,
  input  pocket_pkg::core_video_t   core_video,
  input  logic                      byte_ack,
  output logic [31:0]               bridge_rd_data,
  output pocket_pkg::buttons_t      buttons,
  output logic                      blending_enabled,
  output logic                      byte_req,
  output pocket_pkg::byte_write_t   byte_out,
  output pocket_pkg::scaler_video_t scaler_video
);

  logic                       load_word_valid;
  logic [31:0]                load_word;
  logic [23:0]                load_offset;
  logic                       load_done;
  pocket_pkg::loader_status_t loader_status;

  //////////////////////////////
  // controller 1 key bitmap
  //////////////////////////////

  // face buttons
  assign buttons.a      = cont1_key[4];
  assign buttons.b      = cont1_key[5];
  assign buttons.select = cont1_key[14];
  // shoulder triggers
  assign buttons.trig_l = cont1_key[8];
  assign buttons.trig_r = cont1_key[9];
  // dpad
  assign buttons.up     = cont1_key[0];
  assign buttons.down   = cont1_key[1];
  assign buttons.left   = cont1_key[2];
  assign buttons.right  = cont1_key[3];

  //////////////////////////////
  // blocks
  //////////////////////////////

  bridge_regs u_regs (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge           (bridge),
    .loader_status    (loader_status),
    .bridge_rd_data   (bridge_rd_data),
    .blending_enabled (blending_enabled),
    .load_word_valid  (load_word_valid),
    .load_word        (load_word),
    .load_offset      (load_offset),
    .load_done        (load_done)
  );

  rom_loader u_loader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .load_word_valid (load_word_valid),
    .load_word       (load_word),
    .load_offset     (load_offset),
    .load_done       (load_done),
    .byte_ack        (byte_ack),
    .byte_req        (byte_req),
    .byte_out        (byte_out),
    .loader_status   (loader_status)
  );

  video_conditioner u_video (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_video      (core_video),
    .scaler_video    (scaler_video)
  );

endmodule

/* hw/pocket_pkg.sv */
// pokemon mini wrapper types
// bridge request, rom byte stream, buttons and video bundles
package pocket_pkg;

  `include "pocket_consts.svh"

  // region view of a bridge address
  typedef struct packed {
    logic [7:0]  region;
    logic [23:0] offset;
  } bridge_region_t;

  // one address word, read raw for register hits
  // or split into region and offset for windows
  typedef union packed {
    logic [31:0]    raw;
    bridge_region_t rgn;
  } bridge_addr_u;

  // host bus request, all on clk_74a
  typedef struct packed {
    bridge_addr_u addr;
    logic         rd;
    logic         wr;
    logic [31:0]  wr_data;
  } bridge_req_t;

  // one rom byte toward the core memory
  typedef struct packed {
    logic [`POCKET_LOAD_ADDR_W-1:0] addr;
    logic [7:0]                     data;
  } byte_write_t;

  // loader state as seen by the host
  typedef struct packed {
    logic        download;
    logic        busy;
    logic [23:0] byte_count;
  } loader_status_t;

  // console buttons, active high
  typedef struct packed {
    logic a;
    logic b;
    logic select;
    logic trig_l;
    logic trig_r;
    logic up;
    logic down;
    logic left;
    logic right;
  } buttons_t;

  // raw video out of the emulated core
  typedef struct packed {
    logic [`POCKET_RGB_W-1:0] rgb;
    logic                     hblank;
    logic                     vblank;
    logic                     hsync;
    logic                     vsync;
  } core_video_t;

  // conditioned video for the scaler
  typedef struct packed {
    logic [`POCKET_RGB_W-1:0] rgb;
    logic                     de;
    logic                     hs;
    logic                     vs;
  } scaler_video_t;

endpackage

/* hw/rom_loader.sv */
// rom loader
// splits big-endian bridge words into four bytes and hands
// them off over a four-phase req/ack handshake
// also keeps the download flag and the handed-off byte count
`timescale 1ns/1ns
`include "pocket_consts.svh"

module rom_loader (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  logic                       load_word_valid,
  input  logic [31:0]                load_word,
  input  logic [23:0]                load_offset,
  input  logic                       load_done,
  input  logic                       byte_ack,
  output logic                       byte_req,
  output pocket_pkg::byte_write_t    byte_out,
  output pocket_pkg::loader_status_t loader_status
);

  // handshake states
  localparam logic [1:0] ST_IDLE = 2'd0;
  // word held, waiting for ack low before first req
  localparam logic [1:0] ST_ARM  = 2'd1;
  // req high, waiting for ack
  localparam logic [1:0] ST_REQ  = 2'd2;
  // req low again, waiting for ack to drop
  localparam logic [1:0] ST_REL  = 2'd3;

  logic [1:0]                     state;
  logic [1:0]                     byte_idx;
  logic [31:0]                    word_q;
  logic [`POCKET_LOAD_ADDR_W-3:0] word_addr_q;
  logic                           download;
  logic [23:0]                    byte_count;

  //////////////////////////////
  // byte output
  //////////////////////////////

  // word offset times four plus byte index, msb byte first
  assign byte_out.addr = {word_addr_q, byte_idx};
  assign byte_out.data = word_q[{~byte_idx, 3'b000} +: 8];

  assign loader_status.download   = download;
  assign loader_status.busy       = state != ST_IDLE;
  assign loader_status.byte_count = byte_count;

  // word and base address, only taken while idle
  // a write during busy is lost
  always_ff @(posedge clk_74a) begin
    if (load_word_valid && state == ST_IDLE) begin
      word_q      <= load_word;
      word_addr_q <= load_offset[`POCKET_LOAD_ADDR_W-3:0];
    end
  end

  //////////////////////////////
  // handshake fsm
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state      <= ST_IDLE;
      byte_idx   <= 2'd0;
      byte_req   <= 1'b0;
      byte_count <= 24'd0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (load_word_valid) begin
            byte_idx <= 2'd0;
            state    <= ST_ARM;
          end
        end
        ST_ARM: begin
          // req only rises with ack low
          if (!byte_ack) begin
            byte_req <= 1'b1;
            state    <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (byte_ack) begin
            byte_req   <= 1'b0;
            byte_count <= byte_count + 24'd1;
            state      <= ST_REL;
          end
        end
        default: begin
          // ack dropped, next byte or done
          if (!byte_ack) begin
            if (byte_idx == 2'd3) begin
              state <= ST_IDLE;
            end else begin
              byte_idx <= byte_idx + 2'd1;
              byte_req <= 1'b1;
              state    <= ST_REQ;
            end
          end
        end
      endcase
    end
  end

  // download flag, set by any loader write, cleared by the host
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      download <= 1'b0;
    end else if (load_done) begin
      download <= 1'b0;
    end else if (load_word_valid) begin
      download <= 1'b1;
    end
  end

endmodule

/* hw/video_conditioner.sv */
// video conditioner
// data enable from blanking, masked rgb, and one-cycle
// sync pulses for the scaler
`timescale 1ns/1ns
`include "pocket_consts.svh"

module video_conditioner (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  pocket_pkg::core_video_t   core_video,
  output pocket_pkg::scaler_video_t scaler_video
);

  logic       de_next;
  logic       hs_prev;
  logic       vs_prev;
  logic       hs_rise;
  logic       vs_rise;
  logic [2:0] hs_delay;

  //////////////////////////////
  // edge detect
  //////////////////////////////

  // active video only when neither blank is set
  assign de_next = ~(core_video.hblank | core_video.vblank);

  assign hs_rise = core_video.hsync & ~hs_prev;
  assign vs_rise = core_video.vsync & ~vs_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      hs_prev <= core_video.hsync;
      vs_prev <= core_video.vsync;
    end
  end

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      scaler_video <= '0;
      hs_delay     <= 3'd0;
    end else begin
      scaler_video.de <= de_next;
      // black outside active video
      scaler_video.rgb <= de_next ? core_video.rgb : '0;

      // vs pulse right after the rising edge
      scaler_video.vs <= vs_rise;

      // hs pushed out so it never sits next to vs
      // a newer edge cancels the pending pulse
      scaler_video.hs <= (hs_delay == 3'd1) && !hs_rise;

      if (hs_rise) begin
        // restart on every new edge
        hs_delay <= `POCKET_HS_DELAY;
      end else if (hs_delay != 3'd0) begin
        hs_delay <= hs_delay - 3'd1;
      end
    end
  end

endmodule

/* tests/tb_checker.sv */
// checker for the pokemon mini wrapper
// models the register map, the byte stream and the video timing
// and compares every DUT output once per cycle, mid-cycle
`timescale 1ns/1ns
`include "pocket_consts.svh"

module tb_checker (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  pocket_pkg::bridge_req_t   bridge,
  input  logic [15:0]               cont1_key,
  input  pocket_pkg::core_video_t   core_video,
  input  logic                      byte_ack,
  input  logic [31:0]               bridge_rd_data,
  input  pocket_pkg::buttons_t      buttons,
  input  logic                      blending_enabled,
  input  logic                      byte_req,
  input  pocket_pkg::byte_write_t   byte_out,
  input  pocket_pkg::scaler_video_t scaler_video,
  output int                        value_errors,
  output int                        proto_errors
);

  // register and loader model
  logic                    settings_m;
  logic                    dl_m;
  logic                    busy_m;
  logic [23:0]             cnt_m;
  int                      bytes_m;
  logic                    accept;
  pocket_pkg::byte_write_t exp_bytes[$];
  pocket_pkg::byte_write_t held;
  logic                    req_prev;
  logic                    ack_prev;
  // video model, register contents expected after the last edge
  logic                    exp_de;
  logic [23:0]             exp_rgb;
  logic                    exp_vs;
  logic [3:0]              hs_cnt;
  logic                    hs_seen;
  logic                    vs_seen;

  initial begin
    value_errors = 0;
    proto_errors = 0;
  end

  //////////////////////////////
  // reference functions
  //////////////////////////////

  // status window, then settings, else zero
  function automatic logic [31:0] expected_read(input logic [31:0] a, input logic set,
                                                input logic dl, input logic busy,
                                                input logic [23:0] cnt);
    if (a[31:24] == `POCKET_STATUS_REGION) return {cnt, 6'b0, busy, dl};
    if (a == `POCKET_REG_SETTINGS) return {31'b0, set};
    return 32'b0;
  endfunction

  function automatic pocket_pkg::buttons_t expected_buttons(input logic [15:0] k);
    pocket_pkg::buttons_t b;
    b.a      = k[4];
    b.b      = k[5];
    b.select = k[14];
    b.trig_l = k[8];
    b.trig_r = k[9];
    b.up     = k[0];
    b.down   = k[1];
    b.left   = k[2];
    b.right  = k[3];
    return b;
  endfunction

  // big-endian unpack, byte idx at offset*4+idx mod 2^25
  function automatic pocket_pkg::byte_write_t expected_byte(input logic [31:0] w,
                                                           input logic [23:0] ofs,
                                                           input int idx);
    pocket_pkg::byte_write_t b;
    logic [25:0]             full;
    full   = {ofs, 2'b00} + 26'(idx);
    b.addr = full[`POCKET_LOAD_ADDR_W-1:0];
    b.data = w[8 * (3 - idx) +: 8];
    return b;
  endfunction

  task automatic value_mismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("CHECK FAILED @%0t: %s got %0h expected %0h", $time, what, got, exp);
    value_errors++;
  endtask

  task automatic protocol_error(input string what);
    $display("handshake broken at %0t ns: %s", $time, what);
    proto_errors++;
  endtask

  //////////////////////////////
  // per-cycle compare
  //////////////////////////////

  always @(negedge clk_74a) begin
    if (!pll_core_locked) begin
      settings_m = 1'b0;
      dl_m       = 1'b0;
      busy_m     = 1'b0;
      cnt_m      = '0;
      bytes_m    = 0;
      exp_bytes.delete();
      req_prev   = 1'b0;
      ack_prev   = 1'b0;
      exp_de     = 1'b0;
      exp_rgb    = '0;
      exp_vs     = 1'b0;
      hs_cnt     = '0;
      hs_seen    = 1'b0;
      vs_seen    = 1'b0;
      // outputs held at zero in reset
      if (byte_req !== 1'b0) value_mismatch("byte_req in reset", byte_req, 0);
      if (blending_enabled !== 1'b0) value_mismatch("blending in reset", blending_enabled, 0);
      if (scaler_video !== '0) value_mismatch("video in reset", scaler_video, 0);
    end else begin
      if (buttons !== expected_buttons(cont1_key))
        value_mismatch("buttons", buttons, expected_buttons(cont1_key));
      if (bridge.rd && bridge_rd_data !== expected_read(bridge.addr.raw, settings_m, dl_m,
                                                        busy_m, cnt_m))
        value_mismatch($sformatf("read of %h", bridge.addr.raw), bridge_rd_data,
                       expected_read(bridge.addr.raw, settings_m, dl_m, busy_m, cnt_m));
      if (blending_enabled !== settings_m)
        value_mismatch("blending_enabled", blending_enabled, settings_m);

      // video against the model
      if (scaler_video.de !== exp_de) value_mismatch("de", scaler_video.de, exp_de);
      if (scaler_video.rgb !== exp_rgb) value_mismatch("rgb", scaler_video.rgb, exp_rgb);
      if (scaler_video.vs !== exp_vs) value_mismatch("vs", scaler_video.vs, exp_vs);
      if (scaler_video.hs !== (hs_cnt == 4'd1))
        value_mismatch("hs", scaler_video.hs, hs_cnt == 4'd1);

      // four-phase rules, prev values are what the dut saw at the edge
      if (byte_req && !req_prev) begin
        if (ack_prev) protocol_error("byte_req rose while byte_ack was still high");
        if (exp_bytes.size() == 0) begin
          protocol_error("byte_req rose with no byte expected");
        end else if (byte_out !== exp_bytes[0]) begin
          value_mismatch("byte_out", byte_out, exp_bytes[0]);
        end
        held = byte_out;
      end
      if (byte_req && req_prev && byte_out !== held)
        protocol_error("byte_out changed while byte_req was high");
      if (req_prev && ack_prev && byte_req)
        protocol_error("byte_req stayed high after byte_ack was seen");
      if (req_prev && !ack_prev && !byte_req)
        protocol_error("byte_req dropped before byte_ack");

      // completion, counted at the next edge
      if (byte_req && byte_ack) begin
        if (exp_bytes.size() != 0) void'(exp_bytes.pop_front());
        cnt_m   = cnt_m + 24'd1;
        bytes_m = bytes_m + 1;
      end

      // loader write only taken while idle
      accept = bridge.wr && bridge.addr.raw[31:28] == `POCKET_LOADER_REGION && !busy_m;
      if (busy_m && bytes_m == 4 && !byte_req && !byte_ack) busy_m = 1'b0;
      if (accept) begin
        busy_m  = 1'b1;
        bytes_m = 0;
        for (int i = 0; i < 4; i++)
          exp_bytes.push_back(expected_byte(bridge.wr_data, bridge.addr.raw[23:0], i));
      end

      // download flag and settings
      if (bridge.wr && bridge.addr.raw == `POCKET_REG_LOADDONE && bridge.wr_data[0])
        dl_m = 1'b0;
      else if (bridge.wr && bridge.addr.raw[31:28] == `POCKET_LOADER_REGION)
        dl_m = 1'b1;
      if (bridge.wr && bridge.addr.raw == `POCKET_REG_SETTINGS)
        settings_m = bridge.wr_data[0];

      // video for the next edge
      exp_de  = ~(core_video.hblank | core_video.vblank);
      exp_rgb = exp_de ? core_video.rgb : '0;
      exp_vs  = core_video.vsync & ~vs_seen;
      // hs 8 samples after the rise, restart on each new rise
      if (core_video.hsync && !hs_seen) hs_cnt = 4'd8;
      else if (hs_cnt != 4'd0) hs_cnt = hs_cnt - 4'd1;
      hs_seen  = core_video.hsync;
      vs_seen  = core_video.vsync;
      req_prev = byte_req;
      ack_prev = byte_ack;
    end
  end

endmodule

/* tests/tb_top.sv */
// testbench top for the pokemon mini wrapper
// clock, reset, random bridge/key/video stimulus, byte-ack responder,
// watchdog and the closing report
`timescale 1ns/1ns
`include "pocket_consts.svh"

module tb_top;

  localparam int N_SET   = 12;
  localparam int N_WORDS = 20;
  localparam int N_KEYS  = 32;
  localparam int N_VIDEO = 600;
  // reset, settings loop of 10 cycles each, word writes, keys, video, tail
  localparam int STIM_CYCLES = 8 + 2 + N_SET * 10 + N_WORDS * 4 + 8 + N_KEYS + N_VIDEO + 8;
  // worst byte is about 12 cycles with 3-cycle ack waits both ways
  localparam int HS_CYCLES  = N_WORDS * 4 * 12;
  localparam int TIMEOUT_NS = (STIM_CYCLES + HS_CYCLES) * 2 * 4;
  localparam logic [31:0] STATUS_ADDR = {`POCKET_STATUS_REGION, 24'h0};

  logic                      clk_74a;
  logic                      pll_core_locked;
  pocket_pkg::bridge_req_t   bridge;
  logic [15:0]               cont1_key;
  pocket_pkg::core_video_t   core_video;
  logic                      byte_ack;
  logic [31:0]               bridge_rd_data;
  pocket_pkg::buttons_t      buttons;
  logic                      blending_enabled;
  logic                      byte_req;
  pocket_pkg::byte_write_t   byte_out;
  pocket_pkg::scaler_video_t scaler_video;
  int                        value_errors;
  int                        proto_errors;
  logic [31:0]               lfsr_state;

  pocket_core_top uut (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge           (bridge),
    .cont1_key        (cont1_key),
    .core_video       (core_video),
    .byte_ack         (byte_ack),
    .bridge_rd_data   (bridge_rd_data),
    .buttons          (buttons),
    .blending_enabled (blending_enabled),
    .byte_req         (byte_req),
    .byte_out         (byte_out),
    .scaler_video     (scaler_video)
  );

  tb_checker u_checker (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge           (bridge),
    .cont1_key        (cont1_key),
    .core_video       (core_video),
    .byte_ack         (byte_ack),
    .bridge_rd_data   (bridge_rd_data),
    .buttons          (buttons),
    .blending_enabled (blending_enabled),
    .byte_req         (byte_req),
    .byte_out         (byte_out),
    .scaler_video     (scaler_video),
    .value_errors     (value_errors),
    .proto_errors     (proto_errors)
  );

  //////////////////////////////
  // clock and random source
  //////////////////////////////

  // 4 ns period
  initial clk_74a = 1'b0;
  always #2 clk_74a = ~clk_74a;

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  //////////////////////////////
  // bridge access
  //////////////////////////////

  // single-cycle write pulse
  task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
    @(posedge clk_74a);
    #1;
    bridge.addr.raw = a;
    bridge.wr_data  = d;
    bridge.wr       = 1'b1;
    @(posedge clk_74a);
    #1;
    bridge.wr = 1'b0;
  endtask

  // read data is combinational, taken mid-cycle
  task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
    @(posedge clk_74a);
    #1;
    bridge.addr.raw = a;
    bridge.rd       = 1'b1;
    @(negedge clk_74a);
    d = bridge_rd_data;
    @(posedge clk_74a);
    #1;
    bridge.rd = 1'b0;
  endtask

  //////////////////////////////
  // byte consumer
  //////////////////////////////

  initial begin : ack_responder
    logic [31:0] w;
    byte_ack = 1'b0;
    forever begin
      @(negedge clk_74a);
      if (byte_req) begin
        // 0 to 3 idle cycles before ack
        take_bits(2, w);
        repeat (w) @(posedge clk_74a);
        @(posedge clk_74a);
        #1 byte_ack = 1'b1;
        do @(negedge clk_74a); while (byte_req);
        take_bits(2, w);
        repeat (w) @(posedge clk_74a);
        @(posedge clk_74a);
        #1 byte_ack = 1'b0;
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] st;
    lfsr_state      = 32'd3;
    pll_core_locked = 1'b0;
    bridge          = '0;
    cont1_key       = '0;
    core_video      = '0;
    repeat (8) @(posedge clk_74a);
    #1 pll_core_locked = 1'b1;

    // status right out of reset
    bus_read(STATUS_ADDR, st);

    // settings and done register, then readback of all windows
    for (int n = 0; n < N_SET; n++) begin
      take_bits(32, r);
      bus_write(`POCKET_REG_SETTINGS, r);
      take_bits(32, r);
      bus_write(`POCKET_REG_LOADDONE, r);
      bus_read(`POCKET_REG_SETTINGS, st);
      bus_read(STATUS_ADDR, st);
      take_bits(32, r);
      bus_read(r, st);
    end

    // rom download, host polls busy before each word
    for (int n = 0; n < N_WORDS; n++) begin
      take_bits(28, r);
      st = {`POCKET_LOADER_REGION, r[27:0]};
      take_bits(32, r);
      bus_write(st, r);
      do bus_read(STATUS_ADDR, st); while (st[1]);
    end
    bus_write(`POCKET_REG_LOADDONE, 32'd1);
    bus_read(STATUS_ADDR, st);

    // controller keys
    for (int n = 0; n < N_KEYS; n++) begin
      take_bits(16, r);
      @(posedge clk_74a);
      #1 cont1_key = r[15:0];
    end

    // video, syncs toggle now and then, blanking every cycle
    for (int n = 0; n < N_VIDEO; n++) begin
      @(posedge clk_74a);
      #1;
      take_bits(24, r);
      core_video.rgb = r[23:0];
      take_bits(2, r);
      core_video.hblank = r[0];
      core_video.vblank = r[1];
      take_bits(3, r);
      if (r[2:0] == 3'd0) core_video.hsync = ~core_video.hsync;
      take_bits(4, r);
      if (r[3:0] == 4'd0) core_video.vsync = ~core_video.vsync;
    end

    repeat (12) @(posedge clk_74a);
    $display("errors: value %0d, handshake %0d", value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns, stimulus did not finish", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
